/* dtim.f */
+incdir+.
dtim_pkg.sv
dtim_array.sv
dtim_decode.sv
dtim_execute.sv
dtim_result.sv
dtim.sv
dtim_properties.sv
dtim_tb.sv

/* dtim.sv */
module dtim (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t cpu_req,
  output dtim_pkg::mem_rsp_t cpu_rsp,
  output dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  import dtim_pkg::*;

  dtim_front_t front;
  dtim_idx_t front_index;

  dtim_idx_t raddr;
  dtim_idx_t waddr;
  logic wen;
  dtim_tag_t tag_wdata;
  dtim_tag_t tag_rdata;
  logic lock_wdata;
  logic lock_rdata;
  dtim_line_t line_rdata;
  dtim_line_t line_merged;

  dtim_line_t back_line;
  dtim_word_t back_word;
  logic [3:0] back_strb;
  logic [31:0] back_data;
  logic store;
  dtim_state_t state;
  logic bypass;

  dtim_decode decode_i (
    .clk(clk),
    .rst(rst),
    .cpu_req(cpu_req),
    .front(front),
    .front_index(front_index)
  );

  dtim_execute execute_i (
    .clk(clk),
    .rst(rst),
    .front(front),
    .front_index(front_index),
    .tag_rdata(tag_rdata),
    .lock_rdata(lock_rdata),
    .line_rdata(line_rdata),
    .line_merged(line_merged),
    .mem_rsp(mem_rsp),
    .mem_req(mem_req),
    .raddr(raddr),
    .waddr(waddr),
    .wen(wen),
    .tag_wdata(tag_wdata),
    .lock_wdata(lock_wdata),
    .back_line(back_line),
    .back_word(back_word),
    .back_strb(back_strb),
    .back_data(back_data),
    .store(store),
    .state(state),
    .bypass(bypass)
  );

  dtim_result result_i (
    .state(state),
    .back_line(back_line),
    .back_word(back_word),
    .back_strb(back_strb),
    .back_data(back_data),
    .store(store),
    .bypass(bypass),
    .mem_rsp(mem_rsp),
    .cpu_rsp(cpu_rsp),
    .line_merged(line_merged)
  );

  dtim_array #(.payload_t(dtim_tag_t)) tag_array_i (
    .clk(clk),
    .wen(wen),
    .waddr(waddr),
    .wdata(tag_wdata),
    .raddr(raddr),
    .rdata(tag_rdata)
  );

  dtim_array #(.payload_t(dtim_line_t)) line_array_i (
    .clk(clk),
    .wen(wen),
    .waddr(waddr),
    .wdata(line_merged),
    .raddr(raddr),
    .rdata(line_rdata)
  );

  dtim_array #(.payload_t(logic)) lock_array_i (
    .clk(clk),
    .wen(wen),
    .waddr(waddr),
    .wdata(lock_wdata),
    .raddr(raddr),
    .rdata(lock_rdata)
  );

endmodule

/* dtim_array.sv */
`include "dtim_settings.svh"

module dtim_array #(
  parameter type payload_t = logic
) (
  input logic clk,
  input logic wen,
  input dtim_pkg::dtim_idx_t waddr,
  input payload_t wdata,
  input dtim_pkg::dtim_idx_t raddr,
  output payload_t rdata
);

  payload_t mem [`DTIM_LINES] = '{default: '0};

  // A write to the address being read is forwarded to the read port.
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
    if (wen && waddr == raddr) begin
      rdata <= wdata;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* dtim_decode.sv */
`include "dtim_settings.svh"

module dtim_decode (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_req_t cpu_req,
  output dtim_pkg::dtim_front_t front,
  output dtim_pkg::dtim_idx_t front_index
);

  import dtim_pkg::*;

  dtim_idx_t req_index;
  logic req_write;
  logic req_in_window;

  // A fence starts its walk at index zero.
  always_comb begin
    if (cpu_req.fence) begin
      req_index = '0;
    end else begin
      req_index = cpu_req.addr[`DTIM_TAG_LSB-1:`DTIM_IDX_LSB];
    end
    req_write = |cpu_req.wstrb;
    req_in_window = cpu_req.addr >= `DTIM_BASE && cpu_req.addr < `DTIM_TOP;
  end

  // The arrays are read with the index of the incoming request, so their
  // data lines up with the registered request one cycle later.
  assign front_index = cpu_req.valid ? req_index : front.index;

  always_ff @(posedge clk) begin
    if (!rst) begin
      front.wren <= 1'b0;
      front.rden <= 1'b0;
      front.fence <= 1'b0;
      front.index <= '0;
    end else begin
      front.wren <= cpu_req.valid && !cpu_req.fence && req_write;
      front.rden <= cpu_req.valid && !cpu_req.fence && !req_write;
      front.fence <= cpu_req.valid && cpu_req.fence;
      if (cpu_req.valid) begin
        front.tag <= cpu_req.addr[31:`DTIM_TAG_LSB];
        front.index <= req_index;
        front.word <= cpu_req.addr[`DTIM_IDX_LSB-1:2];
        front.addr <= cpu_req.addr;
        front.data <= cpu_req.wdata;
        front.strb <= cpu_req.wstrb;
        front.in_window <= req_in_window;
      end
    end
  end

endmodule

/* dtim_execute.sv */
module dtim_execute (
  input logic clk,
  input logic rst,
  input dtim_pkg::dtim_front_t front,
  input dtim_pkg::dtim_idx_t front_index,
  input dtim_pkg::dtim_tag_t tag_rdata,
  input logic lock_rdata,
  input dtim_pkg::dtim_line_t line_rdata,
  input dtim_pkg::dtim_line_t line_merged,
  input dtim_pkg::mem_rsp_t mem_rsp,
  output dtim_pkg::mem_req_t mem_req,
  output dtim_pkg::dtim_idx_t raddr,
  output dtim_pkg::dtim_idx_t waddr,
  output logic wen,
  output dtim_pkg::dtim_tag_t tag_wdata,
  output logic lock_wdata,
  output dtim_pkg::dtim_line_t back_line,
  output dtim_pkg::dtim_word_t back_word,
  output logic [3:0] back_strb,
  output logic [31:0] back_data,
  output logic store,
  output dtim_pkg::dtim_state_t state,
  output logic bypass
);

  import dtim_pkg::*;

  dtim_state_t state_q;
  mem_req_t mem_q;
  dtim_line_t line_q;
  dtim_tag_t tag_q;
  dtim_idx_t idx_q;
  dtim_word_t word_q;
  dtim_word_t cnt_q;
  logic [3:0] strb_q;
  logic [31:0] data_q;
  logic store_q;

  logic access;
  logic tag_match;
  logic last_word;
  logic last_idx;
  logic wb_last;
  logic load_hit;
  logic fence_done;

  assign access = front.wren || front.rden;
  assign tag_match = tag_rdata == front.tag;
  assign last_word = &cnt_q;
  assign last_idx = &idx_q;
  assign wb_last = state_q == writeback && mem_rsp.ready && last_word;
  assign load_hit = state_q == hit && front.rden && front.in_window && lock_rdata && tag_match;
  assign fence_done = last_idx && ((state_q == fence && !lock_rdata) || wb_last);

  // While walking, the arrays fetch the next index ahead of time.
  assign raddr = (state_q == fence || state_q == writeback) ? idx_q + 1'b1 : front_index;

  // One write port covers all three arrays. Update sets the lock, while
  // the last writeback beat rewrites the line unchanged and clears it.
  assign waddr = idx_q;
  assign wen = state_q == update || wb_last;
  assign tag_wdata = tag_q;
  assign lock_wdata = state_q == update;

  // In hit the line comes straight from the array for a same-cycle answer.
  assign back_line = state_q == hit ? line_rdata : line_q;
  assign back_word = state_q == hit ? front.word : word_q;
  assign back_strb = strb_q;
  assign back_data = data_q;
  assign store = store_q;
  assign bypass = state_q == ldst;

  // A load hit and the end of a fence walk are answered like an update.
  assign state = (load_hit || fence_done) ? update : state_q;

  assign mem_req = mem_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= hit;
      mem_q.valid <= 1'b0;
      mem_q.fence <= 1'b0;
      store_q <= 1'b0;
    end else begin
      case (state_q)
        hit: begin
          if (front.fence) begin
            idx_q <= '0;
            store_q <= 1'b0;
            state_q <= fence;
          end else if (access) begin
            tag_q <= front.tag;
            idx_q <= front.index;
            word_q <= front.word;
            strb_q <= front.strb;
            data_q <= front.data;
            store_q <= front.wren;
            cnt_q <= '0;
            line_q <= line_rdata;
            if (!front.in_window || (lock_rdata && !tag_match)) begin
              mem_q <= '{valid: 1'b1, fence: 1'b0, addr: front.addr,
                         wdata: front.data, wstrb: front.strb};
              state_q <= ldst;
            end else if (!lock_rdata) begin
              mem_q <= '{valid: 1'b1, fence: 1'b0,
                         addr: {front.tag, front.index, dtim_word_t'(0), 2'b00},
                         wdata: 32'd0, wstrb: 4'd0};
              state_q <= miss;
            end else if (front.wren) begin
              state_q <= update;
            end
          end
        end
        miss: begin
          if (mem_rsp.ready) begin
            line_q[cnt_q] <= mem_rsp.rdata;
            if (last_word) begin
              mem_q.valid <= 1'b0;
              state_q <= update;
            end else begin
              cnt_q <= cnt_q + 1'b1;
              mem_q.addr <= mem_q.addr + 32'd4;
            end
          end
        end
        ldst: begin
          if (mem_rsp.ready) begin
            mem_q.valid <= 1'b0;
            state_q <= hit;
          end
        end
        update: begin
          line_q <= line_merged;
          state_q <= hit;
        end
        fence: begin
          if (lock_rdata) begin
            tag_q <= tag_rdata;
            line_q <= line_rdata;
            cnt_q <= '0;
            mem_q <= '{valid: 1'b1, fence: 1'b0,
                       addr: {tag_rdata, idx_q, dtim_word_t'(0), 2'b00},
                       wdata: line_rdata[0], wstrb: 4'hf};
            state_q <= writeback;
          end else if (last_idx) begin
            state_q <= hit;
          end else begin
            idx_q <= idx_q + 1'b1;
          end
        end
        writeback: begin
          if (mem_rsp.ready) begin
            if (last_word) begin
              mem_q.valid <= 1'b0;
              if (last_idx) begin
                state_q <= hit;
              end else begin
                idx_q <= idx_q + 1'b1;
                state_q <= fence;
              end
            end else begin
              cnt_q <= cnt_q + 1'b1;
              mem_q.addr <= mem_q.addr + 32'd4;
              mem_q.wdata <= line_q[cnt_q + 1'b1];
            end
          end
        end
        default: begin
          state_q <= hit;
        end
      endcase
    end
  end

endmodule

/* dtim_pkg.sv */
package dtim_pkg;

  `include "dtim_settings.svh"

  typedef logic [`DTIM_DEPTH-1:0] dtim_idx_t;
  typedef logic [`DTIM_WIDTH-1:0] dtim_word_t;

  // Everything above the index bits of a byte address.
  typedef logic [31-`DTIM_TAG_LSB:0] dtim_tag_t;

  typedef logic [`DTIM_WORDS-1:0][31:0] dtim_line_t;

  // Used both for the core's data port and for the backing memory port.
  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic ready;
  } mem_rsp_t;

  typedef struct packed {
    dtim_tag_t tag;
    dtim_idx_t index;
    dtim_word_t word;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] strb;
    logic wren;
    logic rden;
    logic fence;
    logic in_window;
  } dtim_front_t;

  typedef enum logic [2:0] {
    hit,
    miss,
    ldst,
    update,
    fence,
    writeback
  } dtim_state_t;

endpackage

/* dtim_properties.sv */
module dtim_properties (
  input logic clk,
  input logic rst,
  input dtim_pkg::mem_rsp_t cpu_rsp,
  input dtim_pkg::mem_req_t mem_req,
  input dtim_pkg::mem_rsp_t mem_rsp
);

  int stable_fails = 0;
  int pulse_fails = 0;
  int fence_fails = 0;

  // A memory beat keeps its address, data and strobe until memory takes it.
  beat_stable: assert property (@(posedge clk) disable iff (!rst)
    mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.addr)
      && $stable(mem_req.wdata) && $stable(mem_req.wstrb))
  else begin
    stable_fails++;
    $error("mem_req changed while valid was held without ready");
  end

  ready_pulse: assert property (@(posedge clk) disable iff (!rst)
    cpu_rsp.ready |=> !cpu_rsp.ready)
  else begin
    pulse_fails++;
    $error("cpu_rsp.ready stayed high for more than one cycle");
  end

  // The backing memory never sees a fence.
  no_mem_fence: assert property (@(posedge clk) disable iff (!rst)
    !mem_req.fence)
  else begin
    fence_fails++;
    $error("mem_req.fence was set");
  end

endmodule

/* dtim_result.sv */
module dtim_result (
  input dtim_pkg::dtim_state_t state,
  input dtim_pkg::dtim_line_t back_line,
  input dtim_pkg::dtim_word_t back_word,
  input logic [3:0] back_strb,
  input logic [31:0] back_data,
  input logic store,
  input logic bypass,
  input dtim_pkg::mem_rsp_t mem_rsp,
  output dtim_pkg::mem_rsp_t cpu_rsp,
  output dtim_pkg::dtim_line_t line_merged
);

  import dtim_pkg::*;

  logic [31:0] line_word;
  logic [31:0] store_word;

  assign line_word = back_line[back_word];

  // Store bytes replace the addressed word byte by byte.
  always_comb begin
    store_word = line_word;
    for (int i = 0; i < 4; i++) begin
      if (back_strb[i]) begin
        store_word[8*i +: 8] = back_data[8*i +: 8];
      end
    end
  end

  always_comb begin
    line_merged = back_line;
    if (store) begin
      line_merged[back_word] = store_word;
    end
  end

  // A bypass answers with the memory beat itself.
  always_comb begin
    if (bypass) begin
      cpu_rsp.rdata = mem_rsp.rdata;
    end else begin
      cpu_rsp.rdata = line_word;
    end
    cpu_rsp.ready = state == update || (bypass && mem_rsp.ready);
  end

endmodule

/* dtim_settings.svh */
`ifndef DTIM_SETTINGS_SVH
`define DTIM_SETTINGS_SVH

// Index bits. The DTIM holds 2**DTIM_DEPTH lines.
`define DTIM_DEPTH 4

// Word-in-line bits. Each line holds 2**DTIM_WIDTH words of 32 bits.
`define DTIM_WIDTH 2

`define DTIM_LINES (2 ** `DTIM_DEPTH)
`define DTIM_WORDS (2 ** `DTIM_WIDTH)

// Lowest address bits of the index and the tag fields.
`define DTIM_IDX_LSB (`DTIM_WIDTH + 2)
`define DTIM_TAG_LSB (`DTIM_DEPTH + `DTIM_WIDTH + 2)

// Address window held on chip. The top bound is exclusive.
`define DTIM_BASE 32'h0001_0000
`define DTIM_TOP 32'h0002_0000

`endif

/* dtim_tb.sv */
`include "dtim_settings.svh"

module dtim_tb;

  import dtim_pkg::*;

  localparam int NUM_REQS = 400;
  localparam int WIN_TAGS = 3;
  localparam int WIN_WORDS = WIN_TAGS * `DTIM_LINES * `DTIM_WORDS;
  localparam logic [31:0] OUT_BASE = 32'h0003_0000;

  logic clk = 1'b0;
  logic rst;
  mem_req_t cpu_req;
  mem_rsp_t cpu_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  int seed = 34027;
  int stall_seed = 34027 + 7919;
  int errors = 0;
  int checks = 0;
  int ready_count = 0;

  logic [31:0] ref_mem [logic [31:0]];
  logic [31:0] backing [logic [31:0]];

  // Lock and tag that the DTIM should hold for each index.
  logic locked [`DTIM_LINES];
  dtim_tag_t line_tag [`DTIM_LINES];

  // Beats are packed as address, write data and strobe.
  logic [67:0] seen_beats [$];
  logic [67:0] want_beats [$];

  always #2 clk = ~clk;

  dtim dtim_i (
    .clk(clk),
    .rst(rst),
    .cpu_req(cpu_req),
    .cpu_rsp(cpu_rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  bind dtim dtim_properties props_i (
    .clk(clk),
    .rst(rst),
    .cpu_rsp(cpu_rsp),
    .mem_req(mem_req),
    .mem_rsp(mem_rsp)
  );

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    if (ref_mem.exists(addr)) begin
      return ref_mem[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] backing_read(input logic [31:0] addr);
    if (backing.exists(addr)) begin
      return backing[addr];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] word;
    word = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[8*i +: 8] = data[8*i +: 8];
      end
    end
    return word;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic expect_beat(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    want_beats.push_back({addr, data, strb});
  endtask

  task automatic compare_beats();
    logic [67:0] got;
    logic [67:0] want;
    compare("memory beat count", seen_beats.size(), want_beats.size());
    while (seen_beats.size() > 0 && want_beats.size() > 0) begin
      got = seen_beats.pop_front();
      want = want_beats.pop_front();
      compare("mem_req.addr", got[67:36], want[67:36]);
      compare("mem_req.wstrb", 32'(got[3:0]), 32'(want[3:0]));
      if (want[3:0] != 4'h0) begin
        compare("mem_req.wdata", got[35:4], want[35:4]);
      end
    end
    seen_beats.delete();
    want_beats.delete();
  endtask

  task automatic compare_window();
    logic [31:0] addr;
    for (int w = 0; w < WIN_WORDS; w++) begin
      addr = `DTIM_BASE + 32'(w * 4);
      compare($sformatf("backing[%h]", addr), backing_read(addr), ref_read(addr));
    end
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare("cpu_rsp.ready", 32'(cpu_rsp.ready), 32'd0);
      compare("mem_req.valid", 32'(mem_req.valid), 32'd0);
    end
    @(posedge clk);
    #1;
  endtask

  // Drives a one-cycle strobe and waits for ready. ready_at counts cycles
  // from the strobe cycle to the ready cycle.
  task automatic run_request(input mem_req_t req, output logic [31:0] rdata,
                             output int ready_at);
    int cycle;
    logic done;
    cpu_req = req;
    cycle = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (cpu_rsp.ready) begin
        done = 1'b1;
        rdata = cpu_rsp.rdata;
        ready_at = cycle;
      end
      @(posedge clk);
      #1;
      cpu_req.valid = 1'b0;
      cpu_req.fence = 1'b0;
      cycle++;
    end
  endtask

  // Backing memory with a random stall of 0 to 3 cycles per beat.
  initial begin : backing_memory
    int stall;
    logic [31:0] old;
    stall = -1;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_rsp.ready = 1'b0;
      if (mem_req.valid === 1'b1) begin
        if (stall < 0) begin
          stall = $random(stall_seed) & 3;
        end
        if (stall == 0) begin
          old = backing_read(mem_req.addr);
          mem_rsp.rdata = old;
          if (mem_req.wstrb != 4'h0) begin
            backing[mem_req.addr] = merge_bytes(old, mem_req.wdata, mem_req.wstrb);
          end
          seen_beats.push_back({mem_req.addr, mem_req.wdata, mem_req.wstrb});
          mem_rsp.ready = 1'b1;
          stall = -1;
        end else begin
          stall--;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (rst && cpu_rsp.ready) begin
      ready_count++;
    end
  end

  initial begin : watchdog
    repeat (NUM_REQS * 200) @(posedge clk);
    $display("Timeout: the DUT did not finish %0d requests in %0d cycles",
             NUM_REQS, NUM_REQS * 200);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    mem_req_t req;
    logic [31:0] rdata;
    logic [31:0] expect_word;
    logic [31:0] base;
    logic in_window;
    logic is_hit;
    int ready_at;
    int kind;
    int tag_pick;
    int assert_fails;
    dtim_idx_t idx;
    dtim_tag_t tag;
    cpu_req = '0;
    rst = 1'b0;
    for (int i = 0; i < `DTIM_LINES; i++) begin
      locked[i] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b1;
    idle_check(4);

    for (int n = 0; n < NUM_REQS; n++) begin
      kind = $random(seed) & 15;
      tag_pick = $unsigned($random(seed)) % WIN_TAGS;
      req = '0;
      req.valid = 1'b1;
      is_hit = 1'b0;
      if (kind == 0) begin
        req.fence = 1'b1;
        for (int i = 0; i < `DTIM_LINES; i++) begin
          if (locked[i]) begin
            base = {line_tag[i], dtim_idx_t'(i), {`DTIM_IDX_LSB{1'b0}}};
            for (int w = 0; w < `DTIM_WORDS; w++) begin
              expect_beat(base + 32'(w * 4), ref_read(base + 32'(w * 4)), 4'hf);
            end
          end
          locked[i] = 1'b0;
        end
      end else begin
        if (kind < 4) begin
          req.addr = OUT_BASE | ($random(seed) & 32'h3c);
        end else begin
          req.addr = `DTIM_BASE + 32'(tag_pick * 256) + ($random(seed) & 32'hfc);
        end
        req.wdata = $random(seed);
        if ($random(seed) & 1) begin
          req.wstrb = 4'($random(seed));
          if (req.wstrb == 4'h0) begin
            req.wstrb = 4'hf;
          end
        end
        idx = req.addr[`DTIM_TAG_LSB-1:`DTIM_IDX_LSB];
        tag = req.addr[31:`DTIM_TAG_LSB];
        in_window = req.addr >= `DTIM_BASE && req.addr < `DTIM_TOP;
        if (in_window && !locked[idx]) begin
          base = req.addr & ~32'(`DTIM_WORDS * 4 - 1);
          for (int w = 0; w < `DTIM_WORDS; w++) begin
            expect_beat(base + 32'(w * 4), 32'd0, 4'h0);
          end
          locked[idx] = 1'b1;
          line_tag[idx] = tag;
        end else if (in_window && line_tag[idx] == tag) begin
          is_hit = 1'b1;
        end else begin
          expect_beat(req.addr, req.wdata, req.wstrb);
        end
        expect_word = ref_read(req.addr);
        if (req.wstrb != 4'h0) begin
          ref_mem[req.addr] = merge_bytes(expect_word, req.wdata, req.wstrb);
        end
      end

      run_request(req, rdata, ready_at);

      if (!req.fence && req.wstrb == 4'h0) begin
        compare("cpu_rsp.rdata", rdata, expect_word);
      end
      if (is_hit) begin
        compare("ready cycle", ready_at, (req.wstrb == 4'h0) ? 32'd1 : 32'd2);
      end
      compare_beats();
      compare("ready count", ready_count, n + 1);
      if (req.fence) begin
        compare_window();
      end
    end

    repeat (4) @(posedge clk);
    compare("ready count", ready_count, NUM_REQS);
    assert_fails = dtim_i.props_i.stable_fails + dtim_i.props_i.pulse_fails
                   + dtim_i.props_i.fence_fails;
    $display("Requests %0d, checks %0d, errors %0d, assertion failures %0d",
             NUM_REQS, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* run_dtim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f dtim.f --top-module dtim_tb -o dtim_sim &&
  ./obj_dir/dtim_sim +verilator+error+limit+100 > sim.log 2>&1 ||
  echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -qs '^\*\* PASS \*\*$' sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }
